//--- source/flash_bridge_config.svh
`ifndef FLASH_BRIDGE_CONFIG_SVH
`define FLASH_BRIDGE_CONFIG_SVH

// Bus clock cycles spent on one 16-bit flash access.
`define FLASH_RW_CYCLES 5

// System bus side.
`define BUS_ADDR_W 24
`define BUS_DATA_W 32

// Flash side in half-word units.
`define FLASH_ADDR_W 22
`define FLASH_DATA_W 16

`endif

//--- source/flash_bridge_pkg.sv
`default_nettype none

package flash_bridge_pkg;

  `include "flash_bridge_config.svh"

  // Byte address and data on the system bus.
  typedef logic [`BUS_ADDR_W-1:0] bus_addr_t;
  typedef logic [`BUS_DATA_W-1:0] bus_word_t;
  typedef logic [`BUS_DATA_W/8-1:0] bus_be_t;

  // Half-word address and data on the flash pins.
  typedef logic [`FLASH_ADDR_W-1:0] flash_addr_t;
  typedef logic [`FLASH_DATA_W-1:0] flash_half_t;

  // Word reads walk through both halves, lower first.
  typedef enum logic [1:0] {
    PH_IDLE,
    PH_LOWER,
    PH_UPPER
  } read_phase_e;

  // One 16-bit access, decode to engine.
  typedef struct packed {
    flash_addr_t addr;
    flash_half_t wdata;
    logic        read;
    logic        write;
  } flash_req_t;

  // Engine result with done on the last cycle.
  typedef struct packed {
    flash_half_t rdata;
    logic        done;
  } flash_rsp_t;

endpackage

`default_nettype wire

//--- source/flash_req_decode.sv
`timescale 1ns/1ps
`default_nettype none

module flash_req_decode (
  input  wire                              clk_bus,
  input  wire                              rst_n,
  input  wire flash_bridge_pkg::bus_addr_t bus_addr_i,
  input  wire flash_bridge_pkg::bus_be_t   bus_be_i,
  input  wire flash_bridge_pkg::bus_word_t bus_wdata_i,
  input  wire                              bus_read_i,
  input  wire                              bus_write_i,
  input  wire flash_bridge_pkg::flash_rsp_t rsp_i,
  output flash_bridge_pkg::flash_req_t     req_o,
  output logic                             capture_lo_o,
  output logic                             word_sel_o,
  output logic                             bus_stall_o
);

  import flash_bridge_pkg::*;

  read_phase_e phase_q;
  read_phase_e phase_d;
  logic        word_rd;
  logic        req_present;
  logic        half_sel;
  logic        finishing;

  assign req_present = bus_read_i || bus_write_i;
  assign word_rd     = bus_read_i && (bus_be_i == 4'b1111);

  // Upper half for the second word-read phase or high-lane-only enables.
  assign half_sel = (phase_q == PH_UPPER) || !(|bus_be_i[1:0]);

  always_comb begin
    req_o.addr  = {bus_addr_i[22:2], half_sel};
    req_o.wdata = half_sel ? bus_wdata_i[31:16] : bus_wdata_i[15:0];
    req_o.read  = bus_read_i;
    req_o.write = bus_write_i;
  end

  always_comb begin
    phase_d = phase_q;
    case (phase_q)
      PH_IDLE: begin
        if (word_rd) begin
          phase_d = PH_LOWER;
        end
      end
      PH_LOWER: begin
        if (rsp_i.done) begin
          phase_d = PH_UPPER;
        end
      end
      PH_UPPER: begin
        if (rsp_i.done) begin
          phase_d = PH_IDLE;
        end
      end
      default: phase_d = PH_IDLE;
    endcase
  end

  always_ff @(posedge clk_bus or negedge rst_n) begin
    if (!rst_n) begin
      phase_q <= PH_IDLE;
    end else begin
      phase_q <= phase_d;
    end
  end

  // A word read only finishes on the upper half.
  assign finishing = rsp_i.done && ((phase_q == PH_UPPER) || !word_rd);
  assign bus_stall_o = req_present && !finishing;

  assign capture_lo_o = (phase_q == PH_LOWER) && rsp_i.done;
  assign word_sel_o   = (phase_q == PH_UPPER);

endmodule

`default_nettype wire

//--- source/flash_cycle_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "flash_bridge_config.svh"

module flash_cycle_engine (
  input  wire                                clk_bus,
  input  wire                                rst_n,
  input  wire flash_bridge_pkg::flash_req_t  req_i,
  output flash_bridge_pkg::flash_rsp_t       rsp_o,
  output flash_bridge_pkg::flash_addr_t      flash_addr_o,
  input  wire flash_bridge_pkg::flash_half_t flash_data_i,
  output flash_bridge_pkg::flash_half_t      flash_data_o,
  output logic                               flash_data_oe_o,
  output logic                               flash_we_n_o,
  output logic                               flash_oe_n_o
);

  import flash_bridge_pkg::*;

  localparam int CNT_W = $clog2(`FLASH_RW_CYCLES + 1);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`FLASH_RW_CYCLES);
  localparam logic [CNT_W-1:0] PRE_LAST_CNT = CNT_W'(`FLASH_RW_CYCLES - 1);

  logic             busy_q;
  logic             write_q;
  logic [CNT_W-1:0] cnt_q;
  logic             we_n_q;
  logic             oe_n_q;
  flash_addr_t      addr_q;
  flash_half_t      wdata_q;
  flash_half_t      rdata_q;
  logic             start;
  logic             start_write;
  logic             last;
  logic             pre_last;

  assign start       = !busy_q && (req_i.read || req_i.write);
  // Read wins if both levels are up.
  assign start_write = req_i.write && !req_i.read;
  assign last        = busy_q && (cnt_q == LAST_CNT);
  assign pre_last    = busy_q && (cnt_q == PRE_LAST_CNT);

  always_ff @(posedge clk_bus or negedge rst_n) begin
    if (!rst_n) begin
      busy_q  <= 1'b0;
      write_q <= 1'b0;
      cnt_q   <= '0;
      we_n_q  <= 1'b1;
      oe_n_q  <= 1'b1;
    end else if (start) begin
      busy_q  <= 1'b1;
      write_q <= start_write;
      cnt_q   <= CNT_W'(1);
      we_n_q  <= !start_write;
      oe_n_q  <= start_write;
    end else if (last) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
      oe_n_q <= 1'b1;
      we_n_q <= 1'b1;
    end else if (busy_q) begin
      cnt_q <= cnt_q + CNT_W'(1);
      // Release we_n early so data is still held on its rising edge.
      if (pre_last) begin
        we_n_q <= 1'b1;
      end
    end
  end

  // Address and write data latched at access start.
  always_ff @(posedge clk_bus) begin
    if (start) begin
      addr_q  <= req_i.addr;
      wdata_q <= req_i.wdata;
    end
  end

  // Sampled after oe_n has been low for the full access time.
  always_ff @(posedge clk_bus) begin
    if (pre_last && !write_q) begin
      rdata_q <= flash_data_i;
    end
  end

  assign rsp_o.rdata = rdata_q;
  assign rsp_o.done  = last;

  assign flash_addr_o    = addr_q;
  assign flash_data_o    = wdata_q;
  assign flash_data_oe_o = busy_q && write_q;
  assign flash_we_n_o    = we_n_q;
  assign flash_oe_n_o    = oe_n_q;

endmodule

`default_nettype wire

//--- source/flash_read_merge.sv
`timescale 1ns/1ps
`default_nettype none

module flash_read_merge (
  input  wire                               clk_bus,
  input  wire                               rst_n,
  input  wire flash_bridge_pkg::flash_rsp_t rsp_i,
  input  wire                               capture_lo_i,
  input  wire                               word_sel_i,
  output flash_bridge_pkg::bus_word_t       bus_rdata_o
);

  import flash_bridge_pkg::*;

  flash_half_t lo_buf_q;

  // Lower half kept while the upper access runs.
  always_ff @(posedge clk_bus or negedge rst_n) begin
    if (!rst_n) begin
      lo_buf_q <= '0;
    end else if (capture_lo_i) begin
      lo_buf_q <= rsp_i.rdata;
    end
  end

  always_comb begin
    if (word_sel_i) begin
      bus_rdata_o = {rsp_i.rdata, lo_buf_q};
    end else begin
      // Half-word reads show up on both lanes.
      bus_rdata_o = {rsp_i.rdata, rsp_i.rdata};
    end
  end

endmodule

`default_nettype wire

//--- source/flash_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module flash_bridge_top (
  input  wire                              clk_bus,
  input  wire                              rst_n,
  input  wire flash_bridge_pkg::bus_addr_t bus_addr_i,
  input  wire flash_bridge_pkg::bus_be_t   bus_be_i,
  input  wire flash_bridge_pkg::bus_word_t bus_wdata_i,
  input  wire                              bus_read_i,
  input  wire                              bus_write_i,
  output flash_bridge_pkg::bus_word_t      bus_rdata_o,
  output logic                             bus_stall_o,
  output flash_bridge_pkg::flash_addr_t    flash_addr_o,
  inout  wire flash_bridge_pkg::flash_half_t flash_data_io,
  output logic                             flash_we_n_o,
  output logic                             flash_oe_n_o,
  output logic                             flash_rp_n_o,
  output logic                             flash_byte_n_o,
  output logic [2:0]                       flash_ce_o,
  output logic                             flash_vpen_o
);

  import flash_bridge_pkg::*;

  flash_req_t  req;
  flash_rsp_t  rsp;
  flash_half_t data_out;
  logic        data_oe;
  logic        capture_lo;
  logic        word_sel;

  flash_req_decode u_decode (
    .clk_bus      (clk_bus),
    .rst_n        (rst_n),
    .bus_addr_i   (bus_addr_i),
    .bus_be_i     (bus_be_i),
    .bus_wdata_i  (bus_wdata_i),
    .bus_read_i   (bus_read_i),
    .bus_write_i  (bus_write_i),
    .rsp_i        (rsp),
    .req_o        (req),
    .capture_lo_o (capture_lo),
    .word_sel_o   (word_sel),
    .bus_stall_o  (bus_stall_o)
  );

  flash_cycle_engine u_engine (
    .clk_bus         (clk_bus),
    .rst_n           (rst_n),
    .req_i           (req),
    .rsp_o           (rsp),
    .flash_addr_o    (flash_addr_o),
    .flash_data_i    (flash_data_io),
    .flash_data_o    (data_out),
    .flash_data_oe_o (data_oe),
    .flash_we_n_o    (flash_we_n_o),
    .flash_oe_n_o    (flash_oe_n_o)
  );

  flash_read_merge u_merge (
    .clk_bus      (clk_bus),
    .rst_n        (rst_n),
    .rsp_i        (rsp),
    .capture_lo_i (capture_lo),
    .word_sel_i   (word_sel),
    .bus_rdata_o  (bus_rdata_o)
  );

  // Bidirectional flash data pins.
  assign flash_data_io = data_oe ? data_out : 'z;

  // Tied pins select 16-bit mode, enable all chips and allow programming.
  assign flash_rp_n_o   = rst_n;
  assign flash_byte_n_o = 1'b1;
  assign flash_ce_o     = 3'b000;
  assign flash_vpen_o   = 1'b1;

endmodule

`default_nettype wire

//--- testbench/flash_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module flash_mem_model (
  input  wire flash_bridge_pkg::flash_addr_t flash_addr_i,
  inout  wire flash_bridge_pkg::flash_half_t flash_data_io,
  input  wire                                we_n_i,
  input  wire                                oe_n_i
);

  import flash_bridge_pkg::*;

  // Higher address bits alias onto 64K half-words.
  localparam int MODEL_AW = 16;

  flash_half_t         mem [0:(1 << MODEL_AW)-1];
  logic [MODEL_AW-1:0] idx;

  assign idx = flash_addr_i[MODEL_AW-1:0];

  // Preload with the half-word address XOR A5C3.
  initial begin
    for (int a = 0; a < (1 << MODEL_AW); a++) begin
      mem[a] = a[15:0] ^ 16'hA5C3;
    end
  end

  // Output enable drives the array word onto the data pins.
  assign flash_data_io = !oe_n_i ? mem[idx] : 'z;

  // Write lands on the rising edge of we_n.
  always @(posedge we_n_i) begin
    if (!$isunknown(flash_addr_i)) begin
      mem[idx] = flash_data_io;
    end
  end

endmodule

`default_nettype wire

//--- testbench/flash_bridge_assert.sv
`timescale 1ns/1ps
`default_nettype none

module flash_bridge_assert (
  input wire clk_bus,
  input wire rst_n,
  input wire stall_i,
  input wire we_n_i,
  input wire oe_n_i,
  input wire data_oe_i
);

  // Read and write strobes are exclusive.
  a_strobe_excl: assert property (@(posedge clk_bus) disable iff (!rst_n)
    we_n_i || oe_n_i)
    else $error("we_n and oe_n are low together");

  // Data pins driven while we_n is low or one cycle after it rises.
  a_drive_window: assert property (@(posedge clk_bus) disable iff (!rst_n)
    data_oe_i |-> (!we_n_i || !$past(we_n_i)))
    else $error("flash data bus driven outside the write strobe");

  a_reset_stall: assert property (@(posedge clk_bus) !rst_n |-> !stall_i)
    else $error("bus stall is high during reset");

endmodule

bind flash_bridge_top flash_bridge_assert u_assert (
  .clk_bus   (clk_bus),
  .rst_n     (rst_n),
  .stall_i   (bus_stall_o),
  .we_n_i    (flash_we_n_o),
  .oe_n_i    (flash_oe_n_o),
  .data_oe_i (data_oe)
);

`default_nettype wire

//--- testbench/flash_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "flash_bridge_config.svh"

module flash_bridge_tb;

  import flash_bridge_pkg::*;

  localparam int ACC_CYCLES = `FLASH_RW_CYCLES;
  // About 60 accesses of at most 2*ACC_CYCLES+3 cycles take some 800 cycles.
  localparam int TIMEOUT_CYCLES = 4000;

  logic             clk_bus;
  logic             rst_n;
  bus_addr_t        bus_addr;
  bus_be_t          bus_be;
  bus_word_t        bus_wdata;
  logic             bus_read;
  logic             bus_write;
  bus_word_t        bus_rdata;
  logic             bus_stall;
  flash_addr_t      flash_addr;
  wire flash_half_t flash_data;
  logic             flash_we_n;
  logic             flash_oe_n;
  logic             flash_rp_n;
  logic             flash_byte_n;
  logic [2:0]       flash_ce;
  logic             flash_vpen;

  // Expected flash contents updated on every write.
  flash_half_t shadow [0:65535];
  int          seed = 29;
  int          checks = 0;
  int          errors = 0;
  int          test_errors;
  int          cycle_cnt = 0;
  int          last_stall;
  bus_word_t   last_rdata;
  flash_addr_t last_faddr;
  string       test_name;

  flash_bridge_top u_flash_bridge_top (
    .clk_bus        (clk_bus),
    .rst_n          (rst_n),
    .bus_addr_i     (bus_addr),
    .bus_be_i       (bus_be),
    .bus_wdata_i    (bus_wdata),
    .bus_read_i     (bus_read),
    .bus_write_i    (bus_write),
    .bus_rdata_o    (bus_rdata),
    .bus_stall_o    (bus_stall),
    .flash_addr_o   (flash_addr),
    .flash_data_io  (flash_data),
    .flash_we_n_o   (flash_we_n),
    .flash_oe_n_o   (flash_oe_n),
    .flash_rp_n_o   (flash_rp_n),
    .flash_byte_n_o (flash_byte_n),
    .flash_ce_o     (flash_ce),
    .flash_vpen_o   (flash_vpen)
  );

  flash_mem_model u_flash (
    .flash_addr_i  (flash_addr),
    .flash_data_io (flash_data),
    .we_n_i        (flash_we_n),
    .oe_n_i        (flash_oe_n)
  );

  pullup data_pullup [`FLASH_DATA_W-1:0] (flash_data);

  initial begin
    clk_bus = 1'b0;
    forever #4 clk_bus = ~clk_bus;
  end

  always @(posedge clk_bus) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic check_value(input string what, input bus_word_t expected,
                             input bus_word_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("mismatch %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic end_test();
    $display("%s: %0s, %0d errors", test_name, (test_errors == 0) ? "ok" : "bad", test_errors);
  endtask

  // Model window index from bus bits 16..2 and the half bit.
  function automatic logic [15:0] half_index(input bus_addr_t addr, input logic upper);
    return {addr[16:2], upper};
  endfunction

  function automatic bus_addr_t random_addr();
    return bus_addr_t'($random(seed)) & 24'hFF_FFFC;
  endfunction

  // One bus access that counts the sampled cycles with stall high.
  task automatic bus_access(input logic write, input bus_addr_t addr, input bus_be_t be,
                            input bus_word_t wdata);
    last_stall = 0;
    @(posedge clk_bus);
    bus_addr  <= addr;
    bus_be    <= be;
    bus_wdata <= wdata;
    bus_read  <= !write;
    bus_write <= write;
    @(negedge clk_bus);
    while (bus_stall) begin
      last_stall++;
      @(negedge clk_bus);
    end
    last_rdata = bus_rdata;
    last_faddr = flash_addr;
    @(posedge clk_bus);
    bus_read  <= 1'b0;
    bus_write <= 1'b0;
  endtask

  task automatic reset_test();
    test_name = "reset_state";
    test_errors = 0;
    repeat (9) @(posedge clk_bus);
    @(negedge clk_bus);
    check_value("rp_n in reset", 0, flash_rp_n);
    check_value("stall in reset", 0, bus_stall);
    @(posedge clk_bus);
    rst_n <= 1'b1;
    @(negedge clk_bus);
    check_value("stall", 0, bus_stall);
    check_value("we_n and oe_n", 2'b11, {flash_we_n, flash_oe_n});
    check_value("rp_n", 1, flash_rp_n);
    check_value("byte_n", 1, flash_byte_n);
    check_value("ce", 0, flash_ce);
    check_value("vpen", 1, flash_vpen);
    check_value("data bus released", 16'hFFFF, flash_data);
    end_test();
  endtask

  task automatic half_read_test();
    bus_addr_t   addr;
    flash_half_t exp;
    test_name = "half_read";
    test_errors = 0;
    for (int i = 0; i < 6; i++) begin
      addr = random_addr();
      exp = shadow[half_index(addr, 1'b0)];
      bus_access(1'b0, addr, 4'b0011, '0);
      check_value("lower half", {exp, exp}, last_rdata);
      check_value("lower flash address", {addr[22:2], 1'b0}, last_faddr);
      exp = shadow[half_index(addr, 1'b1)];
      bus_access(1'b0, addr, 4'b1100, '0);
      check_value("upper half", {exp, exp}, last_rdata);
      check_value("upper flash address", {addr[22:2], 1'b1}, last_faddr);
    end
    end_test();
  endtask

  task automatic word_read_test();
    bus_addr_t addr;
    test_name = "word_read";
    test_errors = 0;
    for (int i = 0; i < 20; i++) begin
      addr = random_addr();
      bus_access(1'b0, addr, 4'b1111, '0);
      check_value("word", {shadow[half_index(addr, 1'b1)], shadow[half_index(addr, 1'b0)]},
                  last_rdata);
    end
    end_test();
  endtask

  task automatic half_write_test();
    bus_addr_t addr;
    bus_word_t wr_lo;
    bus_word_t wr_hi;
    test_name = "half_write";
    test_errors = 0;
    for (int i = 0; i < 4; i++) begin
      addr = random_addr();
      wr_lo = $random(seed);
      wr_hi = $random(seed);
      bus_access(1'b1, addr, 4'b0011, wr_lo);
      bus_access(1'b1, addr, 4'b1100, wr_hi);
      shadow[half_index(addr, 1'b0)] = wr_lo[15:0];
      shadow[half_index(addr, 1'b1)] = wr_hi[31:16];
      bus_access(1'b0, addr, 4'b0011, '0);
      check_value("lower readback", {wr_lo[15:0], wr_lo[15:0]}, last_rdata);
      bus_access(1'b0, addr, 4'b1100, '0);
      check_value("upper readback", {wr_hi[31:16], wr_hi[31:16]}, last_rdata);
      bus_access(1'b0, addr, 4'b1111, '0);
      check_value("word readback", {wr_hi[31:16], wr_lo[15:0]}, last_rdata);
    end
    end_test();
  endtask

  task automatic word_write_test();
    bus_addr_t   addr;
    bus_word_t   wdata;
    flash_half_t upper;
    test_name = "word_write";
    test_errors = 0;
    for (int i = 0; i < 3; i++) begin
      addr = random_addr();
      wdata = $random(seed);
      upper = shadow[half_index(addr, 1'b1)];
      bus_access(1'b1, addr, 4'b1111, wdata);
      shadow[half_index(addr, 1'b0)] = wdata[15:0];
      bus_access(1'b0, addr, 4'b1111, '0);
      check_value("lower written, upper kept", {upper, wdata[15:0]}, last_rdata);
    end
    end_test();
  endtask

  task automatic stall_test();
    bus_addr_t addr;
    test_name = "stall";
    test_errors = 0;
    addr = random_addr();
    bus_access(1'b0, addr, 4'b0011, '0);
    check_value("half read stall cycles", ACC_CYCLES, last_stall);
    // Writes back the current upper half so the contents stay known.
    bus_access(1'b1, addr, 4'b1100, {shadow[half_index(addr, 1'b1)], 16'h0000});
    check_value("half write stall cycles", ACC_CYCLES, last_stall);
    bus_access(1'b0, addr, 4'b1111, '0);
    check_value("word read stall long enough", 1, last_stall >= 2 * ACC_CYCLES);
    end_test();
  endtask

  initial begin
    rst_n     <= 1'b0;
    bus_addr  <= '0;
    bus_be    <= '0;
    bus_wdata <= '0;
    bus_read  <= 1'b0;
    bus_write <= 1'b0;
    for (int a = 0; a < 65536; a++) begin
      shadow[a] = a[15:0] ^ 16'hA5C3;
    end
    reset_test();
    half_read_test();
    word_read_test();
    half_write_test();
    word_write_test();
    stall_test();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+source
source/flash_bridge_pkg.sv
source/flash_req_decode.sv
source/flash_cycle_engine.sv
source/flash_read_merge.sv
source/flash_bridge_top.sv
testbench/flash_mem_model.sv
testbench/flash_bridge_assert.sv
testbench/flash_bridge_tb.sv

//--- Bender.yml
package:
  name: flash_bridge

sources:
  - include_dirs:
      - source
    files:
      - source/flash_bridge_pkg.sv
      - source/flash_req_decode.sv
      - source/flash_cycle_engine.sv
      - source/flash_read_merge.sv
      - source/flash_bridge_top.sv

  - target: test
    include_dirs:
      - source
    files:
      - testbench/flash_mem_model.sv
      - testbench/flash_bridge_assert.sv
      - testbench/flash_bridge_tb.sv
